// File: src/lcd_pkg.sv
package lcd_pkg;

	localparam int NUM_PANELS = 4;
	localparam int CLK_PER_US = 2;     // raise to the board clock in MHz

	localparam int POWER_UP_US   = 500;
	localparam int INIT_PULSE_US = 10;
	localparam int WAIT_FUNC_US  = 50;
	localparam int WAIT_DISP_US  = 50;
	localparam int WAIT_CLEAR_US = 200;
	localparam int WAIT_ENTRY_US = 100;

	localparam int XFER_SETUP_US = 1;
	localparam int XFER_HIGH_US  = 13;
	localparam int XFER_LOW_US   = 13;
	localparam int XFER_TOTAL_US = 50;

	localparam int CNT_W = 12;         // must hold POWER_UP_US * CLK_PER_US

	typedef logic [CNT_W-1:0]      cnt_t;
	typedef logic [7:0]            lcd_byte_t;
	typedef logic [9:0]            lcd_word_t;   // {rs, rw, data}
	typedef logic [6:0]            panel_cfg_t;  // {lines, font, on, cursor, blink, inc, shift}
	typedef logic [1:0]            panel_idx_t;
	typedef logic [NUM_PANELS-1:0] panel_vec_t;

	typedef enum logic [1:0] {
		POWER_UP,
		INIT,
		IDLE,
		XFER
	} port_state_e;

	// counter value on the last cycle of a delay given in microseconds
	function automatic cnt_t us_last(input int us);
		return cnt_t'(us * CLK_PER_US - 1);
	endfunction

endpackage

// File: src/lcd_port.sv
`timescale 1ns/1ps

module lcd_port
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  panel_cfg_t cfg,
	input  logic       cmd_valid,
	input  lcd_word_t  cmd_word,
	output logic       cmd_take,
	output logic       bus_req,
	input  logic       bus_gnt,
	output logic       e,
	output lcd_byte_t  bus_data,
	output logic       bus_rs,
	output logic       bus_rw,
	output logic       ready
);

	port_state_e state;
	cnt_t        cnt;
	logic [1:0]  init_step;   // function set, display ctrl, clear, entry mode
	logic        active;      // grant seen, pulse or slot running
	lcd_word_t   xfer_word;   // host word held for the slot

	function automatic lcd_byte_t init_byte(input panel_cfg_t c, input logic [1:0] s);
		case (s)
			2'd0:    return {4'b0011, c[6], c[5], 2'b00};    // function set
			2'd1:    return {5'b00001, c[4], c[3], c[2]};    // display on/off
			2'd2:    return 8'b0000_0001;                    // clear
			default: return {6'b000001, c[1], c[0]};         // entry mode
		endcase
	endfunction

	function automatic cnt_t init_wait(input logic [1:0] s);
		case (s)
			2'd0:    return us_last(WAIT_FUNC_US);
			2'd1:    return us_last(WAIT_DISP_US);
			2'd2:    return us_last(WAIT_CLEAR_US);
			default: return us_last(WAIT_ENTRY_US);
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= POWER_UP;
			cnt       <= '0;
			init_step <= 2'd0;
			active    <= 1'b0;
			cmd_take  <= 1'b0;
			bus_req   <= 1'b0;
			e         <= 1'b0;
			bus_data  <= '0;
			bus_rs    <= 1'b0;
			bus_rw    <= 1'b0;
			ready     <= 1'b0;
		end else begin
			cmd_take <= 1'b0;   // single cycle strobe
			case (state)
				POWER_UP: begin
					if (cnt == us_last(POWER_UP_US)) begin
						cnt       <= '0;
						init_step <= 2'd0;
						bus_req   <= 1'b1;   // ask for the bus for function set
						state     <= INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				INIT: begin
					if (active) begin
						// E high with the command byte
						if (cnt == us_last(INIT_PULSE_US)) begin
							e        <= 1'b0;
							bus_data <= '0;
							bus_req  <= 1'b0;   // release, then wait
							active   <= 1'b0;
							cnt      <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (bus_req) begin
						if (bus_gnt) begin
							active   <= 1'b1;
							e        <= 1'b1;
							bus_data <= init_byte(cfg, init_step);
							cnt      <= '0;
						end
					end else begin
						// execution wait of the current step
						if (cnt == init_wait(init_step)) begin
							cnt <= '0;
							if (init_step == 2'd3) begin
								ready <= 1'b1;
								state <= IDLE;
							end else begin
								init_step <= init_step + 1'b1;
								bus_req   <= 1'b1;
							end
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end

				IDLE: begin
					if (cmd_valid) begin
						cmd_take  <= 1'b1;
						xfer_word <= cmd_word;
						bus_req   <= 1'b1;
						ready     <= 1'b0;
						cnt       <= '0;
						state     <= XFER;
					end
				end

				XFER: begin
					if (!active) begin
						if (bus_gnt) begin
							active   <= 1'b1;
							bus_rs   <= xfer_word[9];
							bus_rw   <= xfer_word[8];
							bus_data <= xfer_word[7:0];
							cnt      <= '0;
						end
					end else begin
						if (cnt == us_last(XFER_SETUP_US))
							e <= 1'b1;                 // setup done
						if (cnt == us_last(XFER_SETUP_US + XFER_HIGH_US))
							e <= 1'b0;                 // falling edge latches the byte
						if (cnt == us_last(XFER_SETUP_US + XFER_HIGH_US + XFER_LOW_US)) begin
							bus_req  <= 1'b0;
							bus_rs   <= 1'b0;
							bus_rw   <= 1'b0;
							bus_data <= '0;
						end
						if (cnt == us_last(XFER_TOTAL_US)) begin
							active <= 1'b0;
							ready  <= 1'b1;
							cnt    <= '0;
							state  <= IDLE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end

				default: state <= POWER_UP;
			endcase
		end
	end

endmodule

// File: src/lcd_dispatch.sv
`timescale 1ns/1ps

module lcd_dispatch
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cmd_wr,
	input  panel_idx_t cmd_panel,
	input  lcd_word_t  cmd_word,
	output logic       cmd_drop,
	output panel_vec_t pending,
	output lcd_word_t  cmd_word_0,
	output lcd_word_t  cmd_word_1,
	output lcd_word_t  cmd_word_2,
	output lcd_word_t  cmd_word_3,
	input  panel_vec_t cmd_take,
	input  panel_vec_t bus_req,
	output panel_vec_t bus_gnt
);

	lcd_word_t  word_q [NUM_PANELS];
	panel_idx_t last_owner;
	panel_idx_t pick_idx;
	logic       pick_any;
	logic       accept;

	assign accept = cmd_wr && !pending[cmd_panel];

	assign cmd_word_0 = word_q[0];
	assign cmd_word_1 = word_q[1];
	assign cmd_word_2 = word_q[2];
	assign cmd_word_3 = word_q[3];

	always_ff @(posedge clk) begin
		if (accept)
			word_q[cmd_panel] <= cmd_word;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending  <= '0;
			cmd_drop <= 1'b0;
		end else begin
			cmd_drop <= cmd_wr && pending[cmd_panel];   // old word stays
			pending  <= pending & ~cmd_take;
			if (accept)
				pending[cmd_panel] <= 1'b1;
		end
	end

	// first requester after the last owner, wrapping around
	always_comb begin
		panel_idx_t cand;
		pick_any = 1'b0;
		pick_idx = last_owner;
		for (int k = 1; k <= NUM_PANELS; k++) begin
			cand = panel_idx_t'(last_owner + k);
			if (!pick_any && bus_req[cand]) begin
				pick_any = 1'b1;
				pick_idx = cand;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bus_gnt    <= '0;
			last_owner <= panel_idx_t'(NUM_PANELS - 1);   // panel 0 wins first
		end else if (!(|(bus_gnt & bus_req))) begin
			// bus free or owner just released
			if (pick_any) begin
				bus_gnt    <= panel_vec_t'(1) << pick_idx;
				last_owner <= pick_idx;
			end else begin
				bus_gnt <= '0;
			end
		end
	end

endmodule

// File: src/lcd_bus_mux.sv
`timescale 1ns/1ps

module lcd_bus_mux
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  panel_vec_t bus_gnt,
	input  lcd_byte_t  bus_data_0,
	input  lcd_byte_t  bus_data_1,
	input  lcd_byte_t  bus_data_2,
	input  lcd_byte_t  bus_data_3,
	input  panel_vec_t bus_rs,
	input  panel_vec_t bus_rw,
	input  panel_vec_t e,
	output lcd_byte_t  lcd_data,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output panel_vec_t lcd_e
);

	lcd_byte_t data_in [NUM_PANELS];
	lcd_byte_t sel_data;
	logic      sel_rs;
	logic      sel_rw;

	assign data_in[0] = bus_data_0;
	assign data_in[1] = bus_data_1;
	assign data_in[2] = bus_data_2;
	assign data_in[3] = bus_data_3;

	// and-or select, grant is one-hot or zero
	always_comb begin
		sel_data = '0;
		sel_rs   = 1'b0;
		sel_rw   = 1'b0;
		for (int i = 0; i < NUM_PANELS; i++) begin
			if (bus_gnt[i]) begin
				sel_data = sel_data | data_in[i];
				sel_rs   = sel_rs | bus_rs[i];
				sel_rw   = sel_rw | bus_rw[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lcd_data <= '0;
			lcd_rs   <= 1'b0;
			lcd_rw   <= 1'b0;
			lcd_e    <= '0;
		end else begin
			lcd_data <= sel_data;
			lcd_rs   <= sel_rs;
			lcd_rw   <= sel_rw;
			lcd_e    <= e;   // same edge as the data pins
		end
	end

endmodule

// File: src/lcd_multi_top.sv
`timescale 1ns/1ps

module lcd_multi_top
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  panel_cfg_t panel_cfg_0,
	input  panel_cfg_t panel_cfg_1,
	input  panel_cfg_t panel_cfg_2,
	input  panel_cfg_t panel_cfg_3,
	input  logic       cmd_wr,
	input  panel_idx_t cmd_panel,
	input  lcd_word_t  cmd_word,
	output logic       cmd_drop,
	output panel_vec_t pending,
	output panel_vec_t ready,
	output panel_vec_t lcd_e,
	output lcd_byte_t  lcd_data,
	output logic       lcd_rs,
	output logic       lcd_rw
);

	panel_cfg_t cfg [NUM_PANELS];
	lcd_word_t  word [NUM_PANELS];
	lcd_byte_t  port_data [NUM_PANELS];
	panel_vec_t port_rs;
	panel_vec_t port_rw;
	panel_vec_t port_e;
	panel_vec_t cmd_take;
	panel_vec_t bus_req;
	panel_vec_t bus_gnt;

	assign cfg[0] = panel_cfg_0;
	assign cfg[1] = panel_cfg_1;
	assign cfg[2] = panel_cfg_2;
	assign cfg[3] = panel_cfg_3;

	lcd_dispatch u_dispatch (
		.clk        (clk),
		.rst        (rst),
		.cmd_wr     (cmd_wr),
		.cmd_panel  (cmd_panel),
		.cmd_word   (cmd_word),
		.cmd_drop   (cmd_drop),
		.pending    (pending),
		.cmd_word_0 (word[0]),
		.cmd_word_1 (word[1]),
		.cmd_word_2 (word[2]),
		.cmd_word_3 (word[3]),
		.cmd_take   (cmd_take),
		.bus_req    (bus_req),
		.bus_gnt    (bus_gnt)
	);

	for (genvar i = 0; i < NUM_PANELS; i++) begin : g_port
		lcd_port u_port (
			.clk       (clk),
			.rst       (rst),
			.cfg       (cfg[i]),
			.cmd_valid (pending[i]),   // pending bit doubles as valid
			.cmd_word  (word[i]),
			.cmd_take  (cmd_take[i]),
			.bus_req   (bus_req[i]),
			.bus_gnt   (bus_gnt[i]),
			.e         (port_e[i]),
			.bus_data  (port_data[i]),
			.bus_rs    (port_rs[i]),
			.bus_rw    (port_rw[i]),
			.ready     (ready[i])
		);
	end

	lcd_bus_mux u_bus_mux (
		.clk        (clk),
		.rst        (rst),
		.bus_gnt    (bus_gnt),
		.bus_data_0 (port_data[0]),
		.bus_data_1 (port_data[1]),
		.bus_data_2 (port_data[2]),
		.bus_data_3 (port_data[3]),
		.bus_rs     (port_rs),
		.bus_rw     (port_rw),
		.e          (port_e),
		.lcd_data   (lcd_data),
		.lcd_rs     (lcd_rs),
		.lcd_rw     (lcd_rw),
		.lcd_e      (lcd_e)
	);

endmodule

// File: sim/tb_lcd_multi.sv
`timescale 1ns/1ps

module tb_lcd_multi
	import lcd_pkg::*;
;

	logic       clk;
	logic       rst;
	panel_cfg_t cfg_r [NUM_PANELS];
	logic       cmd_wr;
	panel_idx_t cmd_panel;
	lcd_word_t  cmd_word;
	logic       cmd_drop;
	panel_vec_t pending;
	panel_vec_t ready;
	panel_vec_t lcd_e;
	lcd_byte_t  lcd_data;
	logic       lcd_rs;
	logic       lcd_rw;

	logic [31:0] lcg_state;
	logic [11:0] exp_q [$];   // {panel, rs, rw, data} in issue order
	panel_vec_t  pend_watch;  // panels whose pending bit must be low at the pulse
	string       test_name;

	lcd_multi_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.panel_cfg_0 (cfg_r[0]),
		.panel_cfg_1 (cfg_r[1]),
		.panel_cfg_2 (cfg_r[2]),
		.panel_cfg_3 (cfg_r[3]),
		.cmd_wr      (cmd_wr),
		.cmd_panel   (cmd_panel),
		.cmd_word    (cmd_word),
		.cmd_drop    (cmd_drop),
		.pending     (pending),
		.ready       (ready),
		.lcd_e       (lcd_e),
		.lcd_data    (lcd_data),
		.lcd_rs      (lcd_rs),
		.lcd_rw      (lcd_rw)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// HD44780 command set for the 8-bit bus
	function automatic lcd_byte_t expected_byte(input panel_cfg_t c, input int step);
		lcd_byte_t b;
		case (step)
			0: b = 8'h30 | (c[6] ? 8'h08 : 8'h00) | (c[5] ? 8'h04 : 8'h00);
			1: b = 8'h08 | (c[4] ? 8'h04 : 8'h00) | (c[3] ? 8'h02 : 8'h00)
				| (c[2] ? 8'h01 : 8'h00);
			2: b = 8'h01;
			default: b = 8'h04 | (c[1] ? 8'h02 : 8'h00) | (c[0] ? 8'h01 : 8'h00);
		endcase
		return b;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic send_cmd(input panel_idx_t p, input lcd_word_t w, input logic drop_exp);
		cmd_wr    = 1'b1;
		cmd_panel = p;
		cmd_word  = w;
		if (!drop_exp)
			exp_q.push_back({p, w});
		@(posedge clk);
		#1;
		cmd_wr = 1'b0;
		assert (cmd_drop == drop_exp) else
			stop_with_error($sformatf("FAIL %s: cmd_drop expected %0d actual %0d",
				test_name, drop_exp, cmd_drop));
	endtask

	task automatic await_ready(input panel_idx_t p, input int limit);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		while (!ready[p] && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (ready[p]) else
			stop_with_error($sformatf("timeout: panel %0d never became ready", p));
	endtask

	task automatic await_all_ready(input int limit);
		int n;
		n = 0;
		while (ready != '1 && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (ready == '1) else
			stop_with_error($sformatf("timeout: not all panels ready, ready=%b", ready));
	endtask

	// command taken and pending bit cleared again
	task automatic await_taken(input panel_idx_t p, input int limit);
		int n;
		n = 0;
		while ((ready[p] || pending[p]) && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (!ready[p] && !pending[p]) else
			stop_with_error($sformatf("timeout: panel %0d never took its command", p));
	endtask

	task automatic drain_expected(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (exp_q.size() == 0) else
			stop_with_error($sformatf("timeout: %0d expected E pulses never seen",
				exp_q.size()));
	endtask

	task automatic check_pulse(input int p, input int unsigned cyc);
		int          idx;
		logic [11:0] ent;
		idx = -1;
		assert (cyc >= POWER_UP_US * CLK_PER_US) else
			stop_with_error($sformatf("E pulse on panel %0d before power-up delay ended", p));
		for (int i = 0; i < exp_q.size(); i++) begin
			if (idx < 0 && exp_q[i][11:10] == p[1:0])
				idx = i;   // oldest entry of this panel
		end
		assert (idx >= 0) else
			stop_with_error($sformatf("unexpected E pulse on panel %0d", p));
		if (idx >= 0) begin
			ent = exp_q[idx];
			assert ({lcd_rs, lcd_rw, lcd_data} == ent[9:0]) else
				stop_with_error($sformatf("FAIL %s: panel %0d expected %h actual %h",
					test_name, p, ent[9:0], {lcd_rs, lcd_rw, lcd_data}));
			if (pend_watch[p]) begin
				assert (!pending[p]) else
					stop_with_error($sformatf("FAIL %s: pending[%0d] expected 0 actual 1",
						test_name, p));
				pend_watch[p] = 1'b0;
			end
			exp_q.delete(idx);
		end
	endtask

	// bus monitor sampling the pins between edges
	initial begin : monitor
		panel_vec_t  prev_e;
		int unsigned cyc;
		prev_e = '0;
		cyc    = 0;
		forever begin
			@(negedge clk);
			if (rst) begin
				cyc    = 0;
				prev_e = '0;
			end else begin
				cyc++;   // cycles since reset release
				assert ($onehot0(lcd_e)) else
					stop_with_error($sformatf("more than one E line high: %b", lcd_e));
				for (int p = 0; p < NUM_PANELS; p++) begin
					if (lcd_e[p] && !prev_e[p])
						check_pulse(p, cyc);
				end
				prev_e = lcd_e;
			end
		end
	end

	initial begin
		logic [31:0] r;
		panel_idx_t  p;
		panel_idx_t  step;
		lcd_word_t   w;
		lcg_state  = 32'd51737;
		rst        = 1'b1;
		cmd_wr     = 1'b0;
		cmd_panel  = '0;
		cmd_word   = '0;
		pend_watch = '0;
		test_name  = "init";
		for (int i = 0; i < NUM_PANELS; i++) begin
			r = lcg_next();
			cfg_r[i] = r[22:16];
			for (int s = 0; s < 4; s++)
				exp_q.push_back({2'(i), 2'b00, expected_byte(cfg_r[i], s)});
		end

		repeat (10) @(posedge clk);
		#1;
		assert (lcd_e == '0 && pending == '0 && ready == '0 && !cmd_drop && lcd_data == '0
			&& !lcd_rs && !lcd_rw && u_dut.bus_req == '0 && u_dut.bus_gnt == '0) else
			stop_with_error("outputs not cleared during reset");
		rst = 1'b0;

		// power-up and init sequence of all panels
		await_all_ready(6000);
		assert (exp_q.size() == 0) else
			stop_with_error("panel became ready before all init commands were seen");

		test_name = "single";
		for (int n = 0; n < 16; n++) begin
			r = lcg_next();
			p = r[17:16];
			w = r[27:18];
			await_ready(p, 2000);
			send_cmd(p, w, 1'b0);
		end
		drain_expected(3000);

		test_name = "burst";
		for (int round = 0; round < 2; round++) begin
			await_all_ready(2000);
			r    = lcg_next();
			p    = r[17:16];
			step = r[18] ? 2'd1 : 2'd3;   // odd step visits every panel
			for (int k = 0; k < NUM_PANELS; k++) begin
				r = lcg_next();
				pend_watch[p] = 1'b1;
				send_cmd(p, r[25:16], 1'b0);
				p = p + step;
			end
			drain_expected(3000);
		end

		test_name = "drop";
		r = lcg_next();
		p = r[17:16];
		await_ready(p, 2000);
		send_cmd(p, r[27:18], 1'b0);
		await_taken(p, 2000);
		r = lcg_next();
		w = r[25:16];
		send_cmd(p, w, 1'b0);    // held while the first slot runs
		send_cmd(p, ~w, 1'b1);   // pending still set so this one is dropped
		drain_expected(3000);
		await_all_ready(2000);
		assert (pending == '0) else
			stop_with_error("commands left over after the drop test");

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: compile.f
src/lcd_pkg.sv
src/lcd_port.sv
src/lcd_dispatch.sv
src/lcd_bus_mux.sv
src/lcd_multi_top.sv
sim/tb_lcd_multi.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the multi-panel LCD testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_lcd_multi \
	-f compile.f \
	-o sim_lcd_multi

# a fatal stop returns nonzero, the log decides the result
./obj_dir/sim_lcd_multi | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation passed"
exit 0
